// File: Makefile
TOP = tb_neptuno_board

.PHONY: compile run clean

compile:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) -f tb.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: board_ctrl.sv
`timescale 1ns/1ps

/*
    Board control
    Sequences the system and game resets, paces the serial pad scan
    once per video line and decodes the OSD status word into DIP settings
*/

module board_ctrl #(
    parameter int JOY_HALF   = 4,
    parameter int RST_CYCLES = 16
) (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic                pll_locked,
    input  logic                rst_req,
    input  logic                downloading,
    input  logic                hs,
    input  logic [31:0]         status,
    output logic                rst,
    output logic                game_rst,
    output logic                joy_clk,
    output logic                joy_load,
    output logic                shift_en,
    output logic                scan_done,
    output board_pkg::dip_cfg_t dip
);

    import board_pkg::*;

    localparam int RW = $clog2(RST_CYCLES + 1);
    localparam int HW = $clog2(2 * JOY_HALF);
    localparam int BW = $clog2(JOY_BITS);

    rst_state_t    rst_st;
    logic [RW-1:0] rst_cnt;
    logic [RW-1:0] game_cnt;
    logic          flip_prev;
    logic          game_cause;

    scan_state_t   scan_st;
    logic [HW-1:0] half_cnt;
    logic [BW-1:0] bit_cnt;
    logic          hs_last;
    logic          hs_rise;
    logic          half_end;
    logic          load_end;

    // System reset, released RST_CYCLES after the PLL locks
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rst_st  <= RST_HOLD;
            rst_cnt <= '0;
        end else if (!pll_locked) begin
            rst_st  <= RST_HOLD;
            rst_cnt <= '0;
        end else begin
            case (rst_st)
                RST_HOLD: begin
                    rst_st  <= RST_COUNT;
                    rst_cnt <= '0;
                end
                RST_COUNT: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == RW'(RST_CYCLES - 1)) begin
                        rst_st <= RST_RUN;
                    end
                end
                default: rst_st <= RST_RUN;
            endcase
        end
    end

    assign rst = rst_st != RST_RUN;

    // A flip change restarts the game as well
    assign game_cause = rst_req | downloading | (dip.dip_flip != flip_prev);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_cnt  <= '0;
            flip_prev <= 1'b0;
        end else begin
            flip_prev <= dip.dip_flip;
            if (game_cause) begin
                game_cnt <= RW'(RST_CYCLES);
            end else if (game_cnt != '0) begin
                game_cnt <= game_cnt - 1'b1;
            end
        end
    end

    assign game_rst = rst | (game_cnt != '0);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip <= '0;
        end else begin
            dip.enable_fm   <= ~status[STATUS_NOFM];
            dip.enable_psg  <= ~status[STATUS_NOPSG];
            dip.dip_test    <= status[STATUS_TEST];
            dip.dip_pause   <= status[STATUS_PAUSE];
            dip.dip_flip    <= status[STATUS_FLIP];
            dip.dip_fxlevel <= status[STATUS_FX +: 2];
        end
    end

    // Pad scan, one per line
    assign hs_rise  = hs & ~hs_last;
    assign half_end = half_cnt == HW'(JOY_HALF - 1);
    assign load_end = half_cnt == HW'(2 * JOY_HALF - 1);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            scan_st   <= SCAN_IDLE;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            hs_last   <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            hs_last   <= hs;
            scan_done <= 1'b0;
            half_cnt  <= half_cnt + 1'b1;
            case (scan_st)
                SCAN_IDLE: begin
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                    if (hs_rise && !rst) begin
                        scan_st <= SCAN_LOAD;
                    end
                end
                SCAN_LOAD: begin
                    if (load_end) begin
                        scan_st  <= SCAN_LOW;
                        half_cnt <= '0;
                    end
                end
                SCAN_LOW: begin
                    if (half_end) begin
                        scan_st  <= SCAN_HIGH;
                        half_cnt <= '0;
                    end
                end
                default: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        if (bit_cnt == BW'(JOY_BITS - 1)) begin
                            scan_st   <= SCAN_IDLE;
                            scan_done <= 1'b1;
                        end else begin
                            scan_st <= SCAN_LOW;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign joy_load = scan_st != SCAN_LOAD;
    assign joy_clk  = scan_st != SCAN_LOW;
    // Sample on the same edge that raises joy_clk
    assign shift_en = (scan_st == SCAN_LOW) && half_end;

endmodule

// File: board_pkg.sv
/*
    Board shell shared definitions
    Joystick and DIP structs, FSM state types, OSD status bit positions
*/

package board_pkg;

    // One pad, active high, coin in the MSB
    typedef struct packed {
        logic coin;
        logic start;
        logic b6;
        logic b5;
        logic b4;
        logic b3;
        logic b2;
        logic b1;
        logic up;
        logic down;
        logic left;
        logic right;
    } joy_bits_t;

    typedef struct packed {
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       dip_pause;
        logic       dip_flip;
        logic [1:0] dip_fxlevel;
    } dip_cfg_t;

    typedef enum logic [1:0] {
        RST_HOLD,
        RST_COUNT,
        RST_RUN
    } rst_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_LOAD,
        SCAN_LOW,
        SCAN_HIGH
    } scan_state_t;

    // OSD status word layout
    localparam int STATUS_FLIP  = 1;
    localparam int STATUS_PAUSE = 2;
    localparam int STATUS_TEST  = 3;
    localparam int STATUS_FX    = 4;
    localparam int STATUS_NOFM  = 6;
    localparam int STATUS_NOPSG = 7;

    // Two pads of 12 bits on one serial chain
    localparam int JOY_BITS = 24;

endpackage

// File: input_map.sv
`timescale 1ns/1ps

/*
    Game input map
    Registers directions, buttons and start with the game polarity and
    turns each coin press into one pulse of fixed width
*/

module input_map #(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int COIN_PULSE             = 8
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 game_rst,
    input  board_pkg::joy_bits_t joy1,
    input  board_pkg::joy_bits_t joy2,
    output logic [9:0]           game_joystick1,
    output logic [9:0]           game_joystick2,
    output logic [1:0]           game_start,
    output logic [1:0]           game_coin
);

    localparam int         CW      = $clog2(COIN_PULSE + 1);
    localparam logic [9:0] JOY_OFF = {10{GAME_INPUTS_ACTIVE_LOW}};

    logic [1:0] coin_in;

    assign coin_in = {joy2.coin, joy1.coin};

    // Low ten bits of the struct are b6 down to right
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_joystick1 <= JOY_OFF;
            game_joystick2 <= JOY_OFF;
            game_start     <= JOY_OFF[1:0];
        end else begin
            game_joystick1 <= JOY_OFF ^ joy1[9:0];
            game_joystick2 <= JOY_OFF ^ joy2[9:0];
            game_start     <= JOY_OFF[1:0] ^ {joy2.start, joy1.start};
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_coin
        logic          last;
        logic [CW-1:0] cnt;

        // Edge detect keeps tracking during game reset so a held coin stays quiet
        always_ff @(posedge clk_sys or negedge rst_n) begin
            if (!rst_n) begin
                last <= 1'b0;
                cnt  <= '0;
            end else begin
                last <= coin_in[i];
                if (game_rst) begin
                    cnt <= '0;
                end else if (coin_in[i] && !last) begin
                    cnt <= CW'(COIN_PULSE);
                end else if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end
            end
        end

        assign game_coin[i] = GAME_INPUTS_ACTIVE_LOW ^ (cnt != '0);
    end

endmodule

// File: joy_serial.sv
`timescale 1ns/1ps

/*
    Serial pad capture
    Shifts the 24-bit pad chain in and splits it into two joystick
    structs once the whole chain has arrived
*/

module joy_serial (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 rst,
    input  logic                 joy_data,
    input  logic                 shift_en,
    input  logic                 scan_done,
    output board_pkg::joy_bits_t joy1,
    output board_pkg::joy_bits_t joy2
);

    import board_pkg::*;

    localparam int PW = $bits(joy_bits_t);

    logic [JOY_BITS-1:0] chain;

    // Pads pull the line low for a pressed button
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            chain <= '0;
        end else if (shift_en) begin
            chain <= {chain[JOY_BITS-2:0], ~joy_data};
        end
    end

    // First bits in end up at the top, pad 1 MSB first
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            joy1 <= '0;
            joy2 <= '0;
        end else if (rst) begin
            joy1 <= '0;
            joy2 <= '0;
        end else if (scan_done) begin
            joy1 <= joy_bits_t'(chain[JOY_BITS-1 -: PW]);
            joy2 <= joy_bits_t'(chain[PW-1:0]);
        end
    end

endmodule

// File: neptuno_board.sv
`timescale 1ns/1ps

/*
    NeptUNO board shell
    Reset sequencing, serial pad scan, game input mapping, DIP decode
    and sigma-delta audio between the board pins and the game core
*/

module neptuno_board #(
    parameter bit SIGNED_SND             = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int JOY_HALF               = 4,
    parameter int COIN_PULSE             = 8,
    parameter int RST_CYCLES             = 16
) (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic                pll_locked,
    input  logic                rst_req,
    input  logic                downloading,
    input  logic                hs,
    input  logic [31:0]         status,
    // Pad chain
    input  logic                joy_data,
    output logic                joy_clk,
    output logic                joy_load,
    // Sound
    input  logic [15:0]         snd_left,
    input  logic [15:0]         snd_right,
    output logic                audio_l,
    output logic                audio_r,
    // Resets and settings
    output logic                rst,
    output logic                game_rst,
    output board_pkg::dip_cfg_t dip,
    // Game inputs
    output logic [9:0]          game_joystick1,
    output logic [9:0]          game_joystick2,
    output logic [1:0]          game_start,
    output logic [1:0]          game_coin
);

    import board_pkg::*;

    logic      shift_en;
    logic      scan_done;
    joy_bits_t joy1;
    joy_bits_t joy2;

    board_ctrl #(
        .JOY_HALF   ( JOY_HALF   ),
        .RST_CYCLES ( RST_CYCLES )
    ) u_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .hs          ( hs          ),
        .status      ( status      ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    ),
        .joy_clk     ( joy_clk     ),
        .joy_load    ( joy_load    ),
        .shift_en    ( shift_en    ),
        .scan_done   ( scan_done   ),
        .dip         ( dip         )
    );

    joy_serial u_joy (
        .clk_sys   ( clk_sys   ),
        .rst_n     ( rst_n     ),
        .rst       ( rst       ),
        .joy_data  ( joy_data  ),
        .shift_en  ( shift_en  ),
        .scan_done ( scan_done ),
        .joy1      ( joy1      ),
        .joy2      ( joy2      )
    );

    input_map #(
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW ),
        .COIN_PULSE             ( COIN_PULSE             )
    ) u_map (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .game_rst       ( game_rst       ),
        .joy1           ( joy1           ),
        .joy2           ( joy2           ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_start     ( game_start     ),
        .game_coin      ( game_coin      )
    );

    snd_dac #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_dac (
        .clk_sys   ( clk_sys   ),
        .rst_n     ( rst_n     ),
        .snd_left  ( snd_left  ),
        .snd_right ( snd_right ),
        .audio_l   ( audio_l   ),
        .audio_r   ( audio_r   )
    );

endmodule

// File: snd_dac.sv
`timescale 1ns/1ps

/*
    Sigma-delta audio DAC
    Two first-order channels, the accumulator carry is the output bit
*/

module snd_dac #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [15:0] snd_left,
    input  logic [15:0] snd_right,
    output logic        audio_l,
    output logic        audio_r
);

    logic [1:0][15:0] sample;
    logic [1:0]       dac_bit;

    // Channel 0 is left
    assign sample = {snd_right, snd_left};

    for (genvar ch = 0; ch < 2; ch++) begin : g_ch
        logic [15:0] level;
        logic [15:0] acc;
        logic [16:0] sum;
        logic        q;

        // Offset binary for signed samples
        assign level = sample[ch] ^ {SIGNED_SND, 15'd0};
        assign sum   = {1'b0, acc} + {1'b0, level};

        always_ff @(posedge clk_sys or negedge rst_n) begin
            if (!rst_n) begin
                acc <= '0;
                q   <= 1'b0;
            end else begin
                acc <= sum[15:0];
                q   <= sum[16];
            end
        end

        assign dac_bit[ch] = q;
    end

    assign audio_l = dac_bit[0];
    assign audio_r = dac_bit[1];

endmodule

// File: tb.f
board_pkg.sv
board_ctrl.sv
joy_serial.sv
input_map.sv
snd_dac.sv
neptuno_board.sv
tb_joy_pad.sv
tb_neptuno_board.sv

// File: tb_joy_pad.sv
`timescale 1ns/1ps

/*
    Serial pad pair model
    Two pads on one chain, pad 1 first and MSB first,
    a pressed button pulls the data line low
*/

module tb_joy_pad (
    input  logic        joy_clk,
    input  logic        joy_load,
    input  logic [11:0] btn1,
    input  logic [11:0] btn2,
    output logic        joy_data
);

    // Idle line is high until the first load
    logic [23:0] chain = '1;

    // Parallel load while joy_load is low, one bit per rising joy_clk after that
    always @(posedge joy_clk or negedge joy_load) begin
        if (!joy_load) begin
            chain <= ~{btn1, btn2};
        end else begin
            chain <= {chain[22:0], 1'b1};
        end
    end

    // Current bit sits at the top of the chain
    assign joy_data = chain[23];

endmodule

// File: tb_neptuno_board.sv
`timescale 1ns/1ps

/*
    Board shell testbench
    Reset sequence, pad scan table, coin shaping, DIP decode,
    game reset causes and audio density on the default shell
*/

module tb_neptuno_board;

    import board_pkg::*;

    localparam int RST_CYCLES     = 16;
    localparam int JOY_HALF       = 4;
    localparam int COIN_PULSE     = 8;
    localparam bit ACTIVE_LOW     = 1'b1;
    localparam int SCAN_LEN       = 2 * JOY_HALF * 25;
    localparam int CHANGE_TIMEOUT = 300;
    localparam int PAD_ROWS       = 8;
    localparam int FIXED_ROWS     = 5;
    localparam int DIP_ROWS       = 8;

    // Fixed pad rows, active high, coin left out
    localparam logic [11:0] PAD1_FIXED [FIXED_ROWS] = '{
        12'h001, 12'h402, 12'h3ff, 12'h000, 12'h155
    };
    localparam logic [11:0] PAD2_FIXED [FIXED_ROWS] = '{
        12'h200, 12'h010, 12'h000, 12'h7ff, 12'h2aa
    };

    // Status word and dip as {fm, psg, test, pause, flip, fx}
    localparam logic [31:0] DIP_STATUS [DIP_ROWS] = '{
        32'h0000_0000, 32'h0000_00c0, 32'h0000_0030, 32'h0000_000e,
        32'h0000_0040, 32'hffff_ff01, 32'h0000_00a5, 32'h0000_005a
    };
    localparam logic [6:0] DIP_EXP [DIP_ROWS] = '{
        7'h60, 7'h00, 7'h63, 7'h7c,
        7'h20, 7'h60, 7'h4a, 7'h35
    };

    logic        clk_sys;
    logic        rst_n;
    logic        pll_locked;
    logic        rst_req;
    logic        downloading;
    logic        hs;
    logic [31:0] status;
    logic        joy_data;
    logic        joy_clk;
    logic        joy_load;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    logic        audio_l;
    logic        audio_r;
    logic        rst;
    logic        game_rst;
    dip_cfg_t    dip;
    logic [9:0]  game_joystick1;
    logic [9:0]  game_joystick2;
    logic [1:0]  game_start;
    logic [1:0]  game_coin;
    logic [11:0] btn1;
    logic [11:0] btn2;

    int   errors;
    int   checks;
    int   test_errors;
    int   coin_active;
    int   coin_pulses;
    int   coin1_active;
    logic coin_was_active;

    logic [11:0] pad1_tab  [PAD_ROWS];
    logic [11:0] pad2_tab  [PAD_ROWS];
    logic [9:0]  exp_joy1  [PAD_ROWS];
    logic [9:0]  exp_joy2  [PAD_ROWS];
    logic [1:0]  exp_start [PAD_ROWS];

    neptuno_board uut (.*);

    tb_joy_pad u_pads (
        .joy_clk  ( joy_clk  ),
        .joy_load ( joy_load ),
        .btn1     ( btn1     ),
        .btn2     ( btn2     ),
        .joy_data ( joy_data )
    );

    initial begin
        clk_sys = 1'b0;
    end

    always #2 clk_sys = ~clk_sys;

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic compare_hex(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic close_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic build_pad_table();
        logic [11:0] p1;
        logic [11:0] p2;
        for (int r = 0; r < PAD_ROWS; r++) begin
            if (r < FIXED_ROWS) begin
                p1 = PAD1_FIXED[r];
                p2 = PAD2_FIXED[r];
            end else begin
                p1 = 12'($urandom) & 12'h7ff;
                p2 = 12'($urandom) & 12'h7ff;
                // Each row must move the joystick outputs
                if (p1[9:0] == pad1_tab[r-1][9:0]) begin
                    p1[0] = ~p1[0];
                end
            end
            pad1_tab[r]  = p1;
            pad2_tab[r]  = p2;
            exp_joy1[r]  = {10{ACTIVE_LOW}} ^ p1[9:0];
            exp_joy2[r]  = {10{ACTIVE_LOW}} ^ p2[9:0];
            exp_start[r] = {2{ACTIVE_LOW}} ^ {p2[10], p1[10]};
        end
    endtask

    task automatic coin_tick();
        logic active;
        tick();
        active = game_coin[0] ^ ACTIVE_LOW;
        if (active) begin
            coin_active++;
        end
        if (active && !coin_was_active) begin
            coin_pulses++;
        end
        coin_was_active = active;
        // Pad 2 coin is never pressed here
        if (game_coin[1] != ACTIVE_LOW) begin
            coin1_active++;
        end
    endtask

    task automatic run_coin_scans(input int scans);
        coin_active     = 0;
        coin_pulses     = 0;
        coin1_active    = 0;
        coin_was_active = 1'b0;
        for (int s = 0; s < scans; s++) begin
            hs = 1'b1;
            coin_tick();
            hs = 1'b0;
            for (int c = 0; c < SCAN_LEN + 8; c++) begin
                coin_tick();
            end
        end
        // Let a late pulse run out
        for (int c = 0; c < 2 * COIN_PULSE; c++) begin
            coin_tick();
        end
    endtask

    task automatic wait_game_idle();
        int n;
        n = 0;
        while (game_rst && n < 4 * RST_CYCLES) begin
            tick();
            n++;
        end
        if (game_rst) begin
            report_timeout("game_rst did not fall before the next cause");
        end
    endtask

    task automatic measure_game_rst(input string cause);
        int n;
        n = 0;
        compare_hex("game_rst", 32'h1, 32'(game_rst));
        while (game_rst && n < 4 * RST_CYCLES) begin
            tick();
            n++;
            compare_hex("rst", 32'h0, 32'(rst));
        end
        if (game_rst) begin
            report_timeout($sformatf("game_rst stayed high after %s", cause));
        end else begin
            compare_hex("game_rst cycles", 32'(RST_CYCLES), 32'(n));
        end
    endtask

    // SIGNED_SND is 0, so the sample is the expected density
    task automatic measure_audio();
        int high_l;
        int high_r;
        high_l = 0;
        high_r = 0;
        for (int c = 0; c < 65536; c++) begin
            tick();
            if (audio_l) begin
                high_l++;
            end
            if (audio_r) begin
                high_r++;
            end
        end
        compare_hex("audio_l high cycles", 32'(snd_left), 32'(high_l));
        compare_hex("audio_r high cycles", 32'(snd_right), 32'(high_r));
    endtask

    initial begin
        int         n;
        logic [9:0] prev1;
        logic [9:0] prev2;

        rst_n       = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        hs          = 1'b0;
        status      = '0;
        snd_left    = '0;
        snd_right   = '0;
        btn1        = '0;
        btn2        = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        void'($urandom(32'h6f488ec1));
        build_pad_table();

        repeat (2) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;

        // Inactive levels straight out of reset
        compare_hex("joy_load", 32'h1, 32'(joy_load));
        compare_hex("joy_clk", 32'h1, 32'(joy_clk));
        compare_hex("game_joystick1", 32'h3ff, 32'(game_joystick1));
        compare_hex("game_joystick2", 32'h3ff, 32'(game_joystick2));
        compare_hex("game_start", 32'h3, 32'(game_start));
        compare_hex("game_coin", 32'h3, 32'(game_coin));
        compare_hex("rst", 32'h1, 32'(rst));
        compare_hex("game_rst", 32'h1, 32'(game_rst));
        compare_hex("audio_l", 32'h0, 32'(audio_l));
        compare_hex("audio_r", 32'h0, 32'(audio_r));
        n = 0;
        while (rst && n < 4 * RST_CYCLES) begin
            tick();
            n++;
        end
        if (rst) begin
            report_timeout("rst never fell after reset release");
        end else begin
            // One cycle in hold to see the lock, then the count
            compare_hex("rst release cycles", 32'(RST_CYCLES + 1), 32'(n));
            compare_hex("game_rst", 32'h0, 32'(game_rst));
        end
        close_test("reset sequence");

        for (int r = 0; r < PAD_ROWS; r++) begin
            btn1  = pad1_tab[r];
            btn2  = pad2_tab[r];
            prev1 = game_joystick1;
            prev2 = game_joystick2;
            hs = 1'b1;
            tick();
            hs = 1'b0;
            n = 0;
            while (game_joystick1 == prev1 && game_joystick2 == prev2 &&
                   n < CHANGE_TIMEOUT) begin
                tick();
                n++;
                // Stray line pulse and new buttons while the chain shifts
                hs = (n == 100);
                if (n == 100) begin
                    btn1 = ~pad1_tab[r] & 12'h7ff;
                    btn2 = ~pad2_tab[r] & 12'h7ff;
                end
            end
            hs = 1'b0;
            if (n == CHANGE_TIMEOUT) begin
                report_timeout($sformatf("row %0d joysticks did not change in %0d cycles",
                                         r, CHANGE_TIMEOUT));
            end
            for (int c = 0; c < SCAN_LEN; c++) begin
                tick();
            end
            compare_hex("game_joystick1", 32'(exp_joy1[r]), 32'(game_joystick1));
            compare_hex("game_joystick2", 32'(exp_joy2[r]), 32'(game_joystick2));
            compare_hex("game_start", 32'(exp_start[r]), 32'(game_start));
        end
        close_test("pad table");

        btn1 = 12'h800;
        btn2 = 12'h000;
        run_coin_scans(3);
        compare_hex("game_coin[0] active cycles", 32'(COIN_PULSE), 32'(coin_active));
        compare_hex("game_coin[0] pulses", 32'h1, 32'(coin_pulses));
        compare_hex("game_coin[1] active cycles", 32'h0, 32'(coin1_active));
        btn1 = 12'h000;
        run_coin_scans(1);
        compare_hex("game_coin[0] active cycles", 32'h0, 32'(coin_active));
        btn1 = 12'h800;
        run_coin_scans(1);
        compare_hex("game_coin[0] active cycles", 32'(COIN_PULSE), 32'(coin_active));
        compare_hex("game_coin[0] pulses", 32'h1, 32'(coin_pulses));
        compare_hex("game_coin[1] active cycles", 32'h0, 32'(coin1_active));
        btn1 = 12'h000;
        close_test("coin shaping");

        for (int r = 0; r < DIP_ROWS; r++) begin
            status = DIP_STATUS[r];
            tick();
            compare_hex("dip", 32'(DIP_EXP[r]), 32'(dip));
        end
        status = '0;
        tick();
        tick();
        wait_game_idle();
        close_test("dip decode");

        rst_req = 1'b1;
        tick();
        rst_req = 1'b0;
        measure_game_rst("rst_req");
        wait_game_idle();
        downloading = 1'b1;
        repeat (5) tick();
        downloading = 1'b0;
        measure_game_rst("downloading");
        wait_game_idle();
        status[STATUS_FLIP] = 1'b1;
        tick();
        tick();
        measure_game_rst("flip set");
        wait_game_idle();
        status[STATUS_FLIP] = 1'b0;
        tick();
        tick();
        measure_game_rst("flip clear");
        close_test("game reset causes");

        snd_left  = 16'h4000;
        snd_right = 16'($urandom);
        measure_audio();
        snd_left  = 16'hc001;
        snd_right = 16'($urandom);
        measure_audio();
        close_test("audio density");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
